//--- Makefile
# Verilator flow for the fixed Huffman coder

TOP := huffman_fixed_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

# the run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } \
		$$0 == "Simulation completed successfully" { ok = 1 } \
		END { exit !ok }'

clean:
	rm -rf obj_dir

//--- sim.f
+incdir+verif
src/huf_pkg.sv
src/huf_lit_coder.sv
src/huf_len_coder.sv
src/huf_dis_coder.sv
src/huf_code_merge.sv
src/huffman_fixed.sv
verif/huffman_fixed_tb.sv

//--- src/huf_code_merge.sv
//----------------------------
// code merge and output reg
//----------------------------

`timescale 1ns/1ps

module huf_code_merge (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               vld_i,
  input  logic               flg_lit_i,
  input  huf_pkg::lit_part_t lit_i,
  input  huf_pkg::len_part_t len_i,
  input  huf_pkg::dis_part_t dis_i,
  output logic               vld_o,
  output huf_pkg::huf_out_t  out_o
);

  localparam huf_pkg::huf_wd_t PAIR_WD_MIN =
    huf_pkg::huf_wd_t'(huf_pkg::LEN_BASE_WD + huf_pkg::DIS_BASE_WD);
  localparam huf_pkg::huf_wd_t PAIR_WD_MAX =
    huf_pkg::huf_wd_t'(huf_pkg::LEN_CODE_WD + huf_pkg::DIS_CODE_WD);

  huf_pkg::huf_out_t nxt;

  //---- merge -----------------
  // length code sits above the distance code
  always_comb begin
    if (flg_lit_i) begin
      nxt.code = huf_pkg::huf_code_t'(lit_i.code);
      nxt.wd   = huf_pkg::huf_wd_t'(lit_i.wd);
    end
    else begin
      nxt.code = (huf_pkg::huf_code_t'(len_i.code) << dis_i.wd)
               | huf_pkg::huf_code_t'(dis_i.code);
      nxt.wd   = huf_pkg::huf_wd_t'(len_i.wd) + huf_pkg::huf_wd_t'(dis_i.wd);
    end
  end

  //---- output register -------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_o <= 1'b0;
      out_o <= '0;
    end
    else begin
      vld_o <= vld_i;
      // hold last word while idle
      if (vld_i) begin
        out_o <= nxt;
      end
    end
  end

  // width range follows the kind of symbol taken a cycle earlier
  out_wd_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    vld_o |-> ($past(flg_lit_i)
               ? (out_o.wd inside {[huf_pkg::LIT_LO_WD:huf_pkg::LIT_HI_WD]})
               : (out_o.wd inside {[PAIR_WD_MIN:PAIR_WD_MAX]}))
  );

endmodule

//--- src/huf_dis_coder.sv
//----------------------------
// match distance coder
//----------------------------

`timescale 1ns/1ps

module huf_dis_coder (
  input  huf_pkg::dis_dat_t  dis_i,
  output huf_pkg::dis_part_t part_o
);

  logic [huf_pkg::DIS_BAND_WD-1:0] band;
  huf_pkg::dis_dat_t               off;
  huf_pkg::dis_dat_t               shr;
  logic [huf_pkg::DIS_BASE_WD-1:0] base;
  logic [huf_pkg::DIS_EXT_MAX-1:0] rev;
  logic [huf_pkg::DIS_EXT_MAX-1:0] ext;

  //---- band select -----------
  always_comb begin
    band = '0;
    for (int i = 1; i < huf_pkg::DIS_BANDS; i++) begin
      if (dis_i >= huf_pkg::DIS_BAND_LO[i]) begin
        band = i[huf_pkg::DIS_BAND_WD-1:0];
      end
    end
  end

  //---- base and extra bits ---
  assign off = dis_i - huf_pkg::DIS_BAND_LO[band];
  assign shr = off >> band;

  // shr is at most 3, so the low bits suffice
  assign base = huf_pkg::DIS_BAND_BASE[band] + shr[huf_pkg::DIS_BASE_WD-1:0];

  always_comb begin
    for (int i = 0; i < huf_pkg::DIS_EXT_MAX; i++) begin
      rev[i] = off[huf_pkg::DIS_EXT_MAX-1-i];
    end
  end

  // keep the band's own extra bits only
  assign ext = rev >> (huf_pkg::DIS_EXT_MAX - band);

  always_comb begin
    part_o.code = (huf_pkg::dis_code_t'(base) << band) | huf_pkg::dis_code_t'(ext);
    part_o.wd   = huf_pkg::code_wd_t'(huf_pkg::DIS_BASE_WD) + huf_pkg::code_wd_t'(band);
  end

endmodule

//--- src/huf_len_coder.sv
//----------------------------
// match length coder
//----------------------------

`timescale 1ns/1ps

module huf_len_coder (
  input  huf_pkg::len_dat_t  len_i,
  output huf_pkg::len_part_t part_o
);

  logic [huf_pkg::LEN_BAND_WD-1:0] band;
  huf_pkg::len_dat_t               off;
  huf_pkg::len_dat_t               shr;
  logic [huf_pkg::LEN_BASE_WD-1:0] base;
  logic [huf_pkg::LEN_EXT_MAX-1:0] rev;
  logic [huf_pkg::LEN_EXT_MAX-1:0] ext;

  //---- band select -----------
  // last band whose start is not above the length
  always_comb begin
    band = '0;
    for (int i = 1; i < huf_pkg::LEN_BANDS; i++) begin
      if (len_i >= huf_pkg::LEN_BAND_LO[i]) begin
        band = i[huf_pkg::LEN_BAND_WD-1:0];
      end
    end
  end

  //---- base and extra bits ---
  assign off  = len_i - huf_pkg::LEN_BAND_LO[band];
  assign shr  = off >> band;
  assign base = huf_pkg::LEN_BAND_BASE[band] + shr;

  // extra bits go out msb first, so mirror the offset
  always_comb begin
    for (int i = 0; i < huf_pkg::LEN_EXT_MAX; i++) begin
      rev[i] = off[huf_pkg::LEN_EXT_MAX-1-i];
    end
  end

  // drop the mirrored bits that belong to the base
  assign ext = rev >> (huf_pkg::LEN_EXT_MAX - band);

  always_comb begin
    part_o.code = (huf_pkg::len_code_t'(base) << band) | huf_pkg::len_code_t'(ext);
    part_o.wd   = huf_pkg::code_wd_t'(huf_pkg::LEN_BASE_WD) + huf_pkg::code_wd_t'(band);
  end

endmodule

//--- src/huf_lit_coder.sv
//----------------------------
// literal coder
//----------------------------

`timescale 1ns/1ps

module huf_lit_coder (
  input  huf_pkg::lit_dat_t  lit_i,
  output huf_pkg::lit_part_t part_o
);

  logic flg_hi;

  // 144..255 take the 9-bit codes
  assign flg_hi = (lit_i > huf_pkg::LIT_SPLIT);

  always_comb begin
    if (flg_hi) begin
      part_o.code = huf_pkg::lit_code_t'(huf_pkg::LIT_HI_BASE + lit_i
                                         - huf_pkg::LIT_SPLIT - 1);
      part_o.wd   = huf_pkg::LIT_HI_WD;
    end
    else begin
      part_o.code = huf_pkg::LIT_LO_BASE + huf_pkg::lit_code_t'(lit_i);
      part_o.wd   = huf_pkg::LIT_LO_WD;
    end
  end

endmodule

//--- src/huf_pkg.sv
//----------------------------
// fixed huffman coder types
//----------------------------

package huf_pkg;

  // symbol field widths
  localparam int LIT_DAT_WD = 8;
  localparam int LEN_DAT_WD = 7;
  localparam int DIS_DAT_WD = 7;

  // base code widths and extra bit limits
  localparam int LEN_BASE_WD = 7;
  localparam int DIS_BASE_WD = 5;
  localparam int LEN_BANDS   = 4;
  localparam int DIS_BANDS   = 5;
  localparam int LEN_BAND_WD = 2;
  localparam int DIS_BAND_WD = 3;
  localparam int LEN_EXT_MAX = LEN_BANDS - 1;
  localparam int DIS_EXT_MAX = DIS_BANDS - 1;

  // code widths
  localparam int LIT_CODE_WD = 9;
  localparam int LEN_CODE_WD = LEN_BASE_WD + LEN_EXT_MAX;
  localparam int DIS_CODE_WD = DIS_BASE_WD + DIS_EXT_MAX;
  localparam int CODE_WD_WD  = 4;
  localparam int HUF_CODE_WD = LEN_CODE_WD + DIS_CODE_WD;
  localparam int HUF_WD_WD   = 5;

  typedef logic [LIT_DAT_WD-1:0]  lit_dat_t;
  typedef logic [LEN_DAT_WD-1:0]  len_dat_t;
  typedef logic [DIS_DAT_WD-1:0]  dis_dat_t;
  typedef logic [LIT_CODE_WD-1:0] lit_code_t;
  typedef logic [LEN_CODE_WD-1:0] len_code_t;
  typedef logic [DIS_CODE_WD-1:0] dis_code_t;
  typedef logic [CODE_WD_WD-1:0]  code_wd_t;
  typedef logic [HUF_CODE_WD-1:0] huf_code_t;
  typedef logic [HUF_WD_WD-1:0]   huf_wd_t;

  //---- literal table ---------
  localparam lit_dat_t  LIT_SPLIT   = 8'd143;
  localparam lit_code_t LIT_LO_BASE = 9'h030;
  localparam lit_code_t LIT_HI_BASE = 9'h190;
  localparam code_wd_t  LIT_LO_WD   = 4'd8;
  localparam code_wd_t  LIT_HI_WD   = 4'd9;

  //---- length table ----------
  localparam len_dat_t LEN_MIN = 7'd3;
  localparam len_dat_t LEN_MAX = 7'd64;
  // band i starts at LO[i] and carries i extra bits
  localparam len_dat_t LEN_BAND_LO [LEN_BANDS] = '{LEN_MIN, 7'd11, 7'd19, 7'd35};
  localparam logic [LEN_BASE_WD-1:0] LEN_BAND_BASE [LEN_BANDS] = '{7'd1, 7'd9, 7'd13, 7'd17};

  //---- distance table --------
  localparam dis_dat_t DIS_MIN = 7'd1;
  localparam dis_dat_t DIS_MAX = 7'd64;
  localparam dis_dat_t DIS_BAND_LO [DIS_BANDS] = '{DIS_MIN, 7'd5, 7'd9, 7'd17, 7'd33};
  localparam logic [DIS_BASE_WD-1:0] DIS_BAND_BASE [DIS_BANDS] =
    '{5'd0, 5'd4, 5'd6, 5'd8, 5'd10};

  typedef struct packed {
    logic     flg_lit;
    lit_dat_t lit;
    len_dat_t len;
    dis_dat_t dis;
  } huf_sym_t;

  typedef struct packed {
    lit_code_t code;
    code_wd_t  wd;
  } lit_part_t;

  typedef struct packed {
    len_code_t code;
    code_wd_t  wd;
  } len_part_t;

  typedef struct packed {
    dis_code_t code;
    code_wd_t  wd;
  } dis_part_t;

  typedef struct packed {
    huf_code_t code;
    huf_wd_t   wd;
  } huf_out_t;

endpackage

//--- src/huffman_fixed.sv
//----------------------------
// fixed huffman coder top
//----------------------------

`timescale 1ns/1ps

module huffman_fixed (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sym_vld_i,
  input  huf_pkg::huf_sym_t sym_i,
  output logic              code_vld_o,
  output huf_pkg::huf_out_t code_o
);

  huf_pkg::lit_part_t lit_part;
  huf_pkg::len_part_t len_part;
  huf_pkg::dis_part_t dis_part;

  //---- table coders ----------
  huf_lit_coder huf_lit_coder_i (
    .lit_i  (sym_i.lit),
    .part_o (lit_part)
  );

  huf_len_coder huf_len_coder_i (
    .len_i  (sym_i.len),
    .part_o (len_part)
  );

  huf_dis_coder huf_dis_coder_i (
    .dis_i  (sym_i.dis),
    .part_o (dis_part)
  );

  //---- merge stage -----------
  huf_code_merge huf_code_merge_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .vld_i     (sym_vld_i),
    .flg_lit_i (sym_i.flg_lit),
    .lit_i     (lit_part),
    .len_i     (len_part),
    .dis_i     (dis_part),
    .vld_o     (code_vld_o),
    .out_o     (code_o)
  );

  // coders only cover the short match and small window range
  sym_len_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (sym_vld_i && !sym_i.flg_lit)
      |-> (sym_i.len inside {[huf_pkg::LEN_MIN:huf_pkg::LEN_MAX]})
  );

  sym_dis_range_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (sym_vld_i && !sym_i.flg_lit)
      |-> (sym_i.dis inside {[huf_pkg::DIS_MIN:huf_pkg::DIS_MAX]})
  );

endmodule

//--- verif/huf_ref_model.svh
//----------------------------
// fixed code reference model
//----------------------------

`ifndef HUF_REF_MODEL_SVH
`define HUF_REF_MODEL_SVH

// mirror the low nbits of val
function automatic int unsigned bit_reverse(input int unsigned val,
                                            input int unsigned nbits);
  int unsigned res;
  res = 0;
  for (int unsigned i = 0; i < nbits; i++) begin
    res = (res << 1) | ((val >> i) & 32'd1);
  end
  return res;
endfunction

function automatic void lit_expect(input int unsigned v, output int unsigned code,
                                   output int unsigned wd);
  if (v <= 32'(huf_pkg::LIT_SPLIT)) begin
    code = 32'(huf_pkg::LIT_LO_BASE) + v;
    wd   = 8;
  end
  else begin
    code = 32'(huf_pkg::LIT_HI_BASE) + v - 144;
    wd   = 9;
  end
endfunction

//---- match pair rules ------
function automatic void len_expect(input int unsigned len, output int unsigned code,
                                   output int unsigned wd);
  int unsigned base;
  int unsigned ext;
  int unsigned lo;
  if (len <= 10) begin
    lo   = 3;
    base = len - 2;
    ext  = 0;
  end
  else if (len <= 18) begin
    lo   = 11;
    base = 9 + (len - 11) / 2;
    ext  = 1;
  end
  else if (len <= 34) begin
    lo   = 19;
    base = 13 + (len - 19) / 4;
    ext  = 2;
  end
  else begin
    lo   = 35;
    base = 17 + (len - 35) / 8;
    ext  = 3;
  end
  // offset in band, reversed below the 7-bit base
  code = (base << ext) | bit_reverse(len - lo, ext);
  wd   = 7 + ext;
endfunction

function automatic void dis_expect(input int unsigned dis, output int unsigned code,
                                   output int unsigned wd);
  int unsigned base;
  int unsigned ext;
  int unsigned lo;
  if (dis <= 4) begin
    lo   = 1;
    base = dis - 1;
    ext  = 0;
  end
  else if (dis <= 8) begin
    lo   = 5;
    base = 4 + (dis - 5) / 2;
    ext  = 1;
  end
  else if (dis <= 16) begin
    lo   = 9;
    base = 6 + (dis - 9) / 4;
    ext  = 2;
  end
  else if (dis <= 32) begin
    lo   = 17;
    base = 8 + (dis - 17) / 8;
    ext  = 3;
  end
  else begin
    lo   = 33;
    base = 10 + (dis - 33) / 16;
    ext  = 4;
  end
  code = (base << ext) | bit_reverse(dis - lo, ext);
  wd   = 5 + ext;
endfunction

// full output word for one symbol
function automatic huf_pkg::huf_out_t sym_expect(input huf_pkg::huf_sym_t s);
  huf_pkg::huf_out_t res;
  int unsigned code;
  int unsigned wd;
  int unsigned lcode;
  int unsigned lwd;
  int unsigned dcode;
  int unsigned dwd;
  if (s.flg_lit) begin
    lit_expect(32'(s.lit), code, wd);
  end
  else begin
    len_expect(32'(s.len), lcode, lwd);
    dis_expect(32'(s.dis), dcode, dwd);
    code = (lcode << dwd) | dcode;
    wd   = lwd + dwd;
  end
  res.code = huf_pkg::huf_code_t'(code);
  res.wd   = huf_pkg::huf_wd_t'(wd);
  return res;
endfunction

`endif

//--- verif/huffman_fixed_tb.sv
//----------------------------
// fixed huffman coder tb
//----------------------------

`timescale 1ns/1ps

module huffman_fixed_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 3;
  localparam int RND_SYMS   = 800;
  // about 1300 cycles of stimulus, with margin
  localparam int MAX_CYCLES = 2000;
  localparam int SYM_WD     = $bits(huf_pkg::huf_sym_t);

  logic              clk_i;
  logic              rst_n_i;
  logic              sym_vld_i;
  huf_pkg::huf_sym_t sym_i;
  logic              code_vld_o;
  huf_pkg::huf_out_t code_o;

  logic              exp_vld;
  huf_pkg::huf_out_t exp_out;
  logic              out_seen;
  int                err_cnt;
  int                sym_cnt;
  int                cyc_cnt;

  `include "huf_ref_model.svh"

  huffman_fixed huffman_fixed_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sym_vld_i  (sym_vld_i),
    .sym_i      (sym_i),
    .code_vld_o (code_vld_o),
    .code_o     (code_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //---- expected output -------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_vld  <= 1'b0;
      exp_out  <= '0;
      out_seen <= 1'b0;
    end
    else begin
      exp_vld  <= sym_vld_i;
      out_seen <= out_seen | exp_vld;
      if (sym_vld_i) begin
        exp_out <= sym_expect(sym_i);
      end
    end
  end

  vld_match_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    code_vld_o == exp_vld
  ) else begin
    err_cnt++;
    $display("FAILED code_vld_o: got %h, expected %h", $sampled(code_vld_o),
             $sampled(exp_vld));
  end

  code_match_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    exp_vld |-> (code_o.code == exp_out.code)
  ) else begin
    err_cnt++;
    $display("FAILED code_o.code: got %h, expected %h", $sampled(code_o.code),
             $sampled(exp_out.code));
  end

  wd_match_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    exp_vld |-> (code_o.wd == exp_out.wd)
  ) else begin
    err_cnt++;
    $display("FAILED code_o.wd: got %h, expected %h", $sampled(code_o.wd),
             $sampled(exp_out.wd));
  end

  // cleared output until the first word comes out
  idle_zero_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!out_seen && !exp_vld) |-> (code_o == '0)
  ) else begin
    err_cnt++;
    $display("FAILED code_o: got %h, expected %h", $sampled(code_o), 0);
  end

  //---- stimulus helpers ------
  function automatic huf_pkg::huf_sym_t lit_symbol(input int unsigned v);
    huf_pkg::huf_sym_t s;
    s.flg_lit = 1'b1;
    s.lit     = huf_pkg::lit_dat_t'(v);
    s.len     = huf_pkg::LEN_MIN;
    s.dis     = huf_pkg::DIS_MIN;
    return s;
  endfunction

  function automatic huf_pkg::huf_sym_t pair_symbol(input int unsigned len,
                                                    input int unsigned dis);
    huf_pkg::huf_sym_t s;
    s.flg_lit = 1'b0;
    s.lit     = '0;
    s.len     = huf_pkg::len_dat_t'(len);
    s.dis     = huf_pkg::dis_dat_t'(dis);
    return s;
  endfunction

  function automatic huf_pkg::huf_sym_t random_symbol();
    huf_pkg::huf_sym_t s;
    s.flg_lit = 1'($urandom_range(1));
    s.lit     = huf_pkg::lit_dat_t'($urandom_range(255));
    s.len     = huf_pkg::len_dat_t'($urandom_range(64, 3));
    s.dis     = huf_pkg::dis_dat_t'($urandom_range(64, 1));
    return s;
  endfunction

  task automatic drive_sym(input huf_pkg::huf_sym_t s);
    @(posedge clk_i);
    #1;
    sym_vld_i = 1'b1;
    sym_i     = s;
    sym_cnt++;
  endtask

  // junk on the bus while the strobe is low
  task automatic drive_idle();
    @(posedge clk_i);
    #1;
    sym_vld_i = 1'b0;
    sym_i     = SYM_WD'($urandom);
  endtask

  task automatic report_totals();
    $display("symbols: %0d, cycles: %0d, errors: %0d", sym_cnt, cyc_cnt, err_cnt);
  endtask

  //---- main sequence ---------
  initial begin : stimulus
    int unsigned seed_val;
    rst_n_i   = 1'b0;
    sym_vld_i = 1'b0;
    sym_i     = '0;
    err_cnt   = 0;
    sym_cnt   = 0;
    seed_val  = $urandom(23);
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (4) drive_idle();
    for (int v = 0; v < 256; v++) begin
      drive_sym(lit_symbol(v));
    end
    for (int l = 3; l <= 64; l++) begin
      drive_sym(pair_symbol(l, 1));
    end
    for (int d = 1; d <= 64; d++) begin
      drive_sym(pair_symbol(3, d));
    end
    for (int n = 0; n < RND_SYMS; n++) begin
      if ($urandom_range(7) == 0) begin
        drive_idle();
      end
      drive_sym(random_symbol());
    end
    repeat (2) drive_idle();
    report_totals();
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end
    else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    cyc_cnt = 0;
    while (cyc_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cyc_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
    report_totals();
    $display("Simulation failed");
    $finish;
  end

endmodule
